// File: common/daf_params.svh
`ifndef DAF_PARAMS_SVH
`define DAF_PARAMS_SVH

// clk cycles per half sck period
`define DAF_SCK_DIV 2

// Bits per audio sample, one channel
`define DAF_SAMPLE_W 16

// Gain scale, 16 means unity for volume and fader
`define DAF_GAIN_SH 4

// Sample value of one pot step
`define DAF_POT_STEP 2048

// Compressor slope above threshold
`define DAF_COMP_RATIO_SH 2

`endif

// File: common/daf_pkg.sv
`include "daf_params.svh"

package daf_pkg;

  // One signed audio sample
  typedef logic signed [`DAF_SAMPLE_W-1:0] sample_t;

  // Stereo frame, left word in the upper half
  typedef logic [2*`DAF_SAMPLE_W-1:0] frame_t;

  // Potentiometer nibble
  typedef logic [3:0] pot_t;

  typedef enum logic [1:0] {
    UNITY,
    FADING,
    SILENT
  } fade_state_t;

endpackage

// File: rtl/clk_div.sv
`timescale 1ns/1ps
`include "daf_params.svh"

module clk_div (
  input  logic clk,
  input  logic rst_n,
  output logic sck,
  output logic ws,
  output logic bit_strobe,
  output logic frame_strobe
);

  localparam int HALF_W = $clog2(`DAF_SCK_DIV + 1);
  localparam int BIT_W  = $clog2(2 * `DAF_SAMPLE_W);

  logic [HALF_W-1:0] half_cnt;
  logic [BIT_W-1:0]  bit_cnt;
  logic              half_last;

  assign half_last = (half_cnt == HALF_W'(`DAF_SCK_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_cnt <= '0;
      bit_cnt  <= '0;
      sck      <= 1'b0;
    end else if (half_last) begin
      half_cnt <= '0;
      sck      <= ~sck;
      // Next bit starts on the falling edge
      if (sck) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // Low for bits 0..15 (left), high for the right word
  assign ws = bit_cnt[BIT_W-1];

  // Cycle just before sck rises
  assign bit_strobe   = half_last & ~sck;
  assign frame_strobe = bit_strobe & (bit_cnt == '0);

endmodule

// File: i2s/i2s_rcvr.sv
`timescale 1ns/1ps

module i2s_rcvr
  import daf_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   bit_strobe,
  input  logic   frame_strobe,
  input  logic   serial_data_in,
  output frame_t rx_frame,
  output logic   rx_valid
);

  localparam int FW = $bits(frame_t);

  frame_t shift_q;
  frame_t cap_q;
  logic   cap_vld;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q  <= '0;
      cap_q    <= '0;
      cap_vld  <= 1'b0;
      rx_frame <= '0;
      rx_valid <= 1'b0;
    end else begin
      // MSB first, left word then right word
      if (bit_strobe) begin
        shift_q <= {shift_q[FW-2:0], serial_data_in};
      end

      // Shift register still holds the whole previous frame here
      cap_vld <= frame_strobe;
      if (frame_strobe) begin
        cap_q <= shift_q;
      end

      rx_valid <= cap_vld;
      if (cap_vld) begin
        rx_frame <= cap_q;
      end
    end
  end

endmodule

// File: i2s/i2s_trnmtr.sv
`timescale 1ns/1ps

module i2s_trnmtr
  import daf_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   bit_strobe,
  input  logic   frame_strobe,
  input  logic   sck,
  input  frame_t fade_frame,
  input  logic   fade_valid,
  output logic   serial_data_out
);

  localparam int FW    = $bits(frame_t);
  localparam int IDX_W = $clog2(FW);

  frame_t           hold_q;
  frame_t           shift_q;
  logic             sck_q;
  logic             sck_fall;
  logic [IDX_W-1:0] bit_idx;

  assign sck_fall = sck_q & ~sck;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_q          <= '0;
      shift_q         <= '0;
      sck_q           <= 1'b0;
      bit_idx         <= '0;
      serial_data_out <= 1'b0;
    end else begin
      sck_q <= sck;

      if (fade_valid) begin
        hold_q <= fade_frame;
      end

      // Index of the bit driven at the next falling edge
      if (frame_strobe) begin
        bit_idx <= IDX_W'(1);
      end else if (bit_strobe) begin
        bit_idx <= bit_idx + 1'b1;
      end

      if (sck_fall) begin
        // Frame boundary, MSB goes out with the ws change
        if (bit_idx == '0) begin
          serial_data_out <= hold_q[FW-1];
          shift_q         <= {hold_q[FW-2:0], 1'b0};
        end else begin
          serial_data_out <= shift_q[FW-1];
          shift_q         <= {shift_q[FW-2:0], 1'b0};
        end
      end
    end
  end

endmodule

// File: rtl/effect_chain.sv
`timescale 1ns/1ps
`include "daf_params.svh"

module effect_chain
  import daf_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  frame_t     rx_frame,
  input  logic       rx_valid,
  input  pot_t       pot_vol,
  input  pot_t       pot_amp_clp,
  input  pot_t       pot_amp_com,
  input  logic [3:0] mode_en,
  output frame_t     chain_frame,
  output logic       chain_valid
);

  localparam int SW    = `DAF_SAMPLE_W;
  localparam int EXT_W = SW + 1;

  typedef logic signed [EXT_W-1:0] ext_t;
  typedef logic signed [SW+4:0]    vprod_t;

  localparam ext_t POT_STEP = ext_t'(`DAF_POT_STEP);

  frame_t     vol_q;
  frame_t     clp_q;
  logic [2:0] vld_q;

  function automatic sample_t vol_scale(sample_t s, pot_t p);
    vprod_t prod;
    vprod_t shifted;
    prod    = vprod_t'(s) * vprod_t'($signed({1'b0, p}));
    shifted = prod >>> `DAF_GAIN_SH;
    return shifted[SW-1:0];
  endfunction

  // Saturate to +/-(p * step + step - 1)
  function automatic sample_t clip(sample_t s, pot_t p);
    ext_t x;
    ext_t lim;
    ext_t neg_lim;
    x       = ext_t'(s);
    lim     = ext_t'($signed({1'b0, p})) * POT_STEP + (POT_STEP - ext_t'(1));
    neg_lim = -lim;
    if (x > lim) begin
      return lim[SW-1:0];
    end
    if (x < neg_lim) begin
      return neg_lim[SW-1:0];
    end
    return s;
  endfunction

  // Magnitude above threshold is divided down, sign kept
  function automatic sample_t compress(sample_t s, pot_t p);
    ext_t x;
    ext_t mag;
    ext_t th;
    ext_t res;
    x   = ext_t'(s);
    mag = x[EXT_W-1] ? -x : x;
    th  = ext_t'($signed({1'b0, p})) * POT_STEP;
    if (mag <= th) begin
      return s;
    end
    res = th + ((mag - th) >>> `DAF_COMP_RATIO_SH);
    if (x[EXT_W-1]) begin
      res = -res;
    end
    return res[SW-1:0];
  endfunction

  // mode_en order: flanger, clip, compress, fader
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vol_q       <= '0;
      clp_q       <= '0;
      chain_frame <= '0;
      vld_q       <= '0;
    end else begin
      vld_q <= {vld_q[1:0], rx_valid};

      if (rx_valid) begin
        vol_q <= {vol_scale(rx_frame[2*SW-1:SW], pot_vol),
                  vol_scale(rx_frame[SW-1:0], pot_vol)};
      end

      if (vld_q[0]) begin
        clp_q <= mode_en[2] ? {clip(vol_q[2*SW-1:SW], pot_amp_clp),
                               clip(vol_q[SW-1:0], pot_amp_clp)} : vol_q;
      end

      if (vld_q[1]) begin
        chain_frame <= mode_en[1] ? {compress(clp_q[2*SW-1:SW], pot_amp_com),
                                     compress(clp_q[SW-1:0], pot_amp_com)} : clp_q;
      end
    end
  end

  assign chain_valid = vld_q[2];

endmodule

// File: rtl/fader.sv
`timescale 1ns/1ps
`include "daf_params.svh"

module fader
  import daf_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   fade_en,
  input  frame_t chain_frame,
  input  logic   chain_valid,
  output frame_t fade_frame,
  output logic   fade_valid
);

  localparam int SW     = `DAF_SAMPLE_W;
  localparam int GAIN_W = `DAF_GAIN_SH + 1;

  typedef logic [GAIN_W-1:0]        gain_t;
  typedef logic signed [SW+GAIN_W:0] gprod_t;

  localparam gain_t UNITY_GAIN = gain_t'(1 << `DAF_GAIN_SH);

  fade_state_t state_q;
  fade_state_t state_d;
  gain_t       gain_q;
  gain_t       gain_d;

  function automatic sample_t apply_gain(sample_t s, gain_t g);
    gprod_t prod;
    gprod_t shifted;
    prod    = gprod_t'(s) * gprod_t'($signed({1'b0, g}));
    shifted = prod >>> `DAF_GAIN_SH;
    return shifted[SW-1:0];
  endfunction

  // One gain step per frame
  always_comb begin
    state_d = state_q;
    gain_d  = gain_q;
    case (state_q)
      UNITY: begin
        if (fade_en) begin
          state_d = FADING;
          gain_d  = UNITY_GAIN - 1'b1;
        end
      end
      FADING: begin
        if (!fade_en) begin
          state_d = UNITY;
          gain_d  = UNITY_GAIN;
        end else if (gain_q == gain_t'(1)) begin
          state_d = SILENT;
          gain_d  = '0;
        end else begin
          gain_d = gain_q - 1'b1;
        end
      end
      SILENT: begin
        if (!fade_en) begin
          state_d = UNITY;
          gain_d  = UNITY_GAIN;
        end
      end
      default: begin
        state_d = UNITY;
        gain_d  = UNITY_GAIN;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= UNITY;
      gain_q     <= UNITY_GAIN;
      fade_frame <= '0;
      fade_valid <= 1'b0;
    end else begin
      fade_valid <= chain_valid;
      if (chain_valid) begin
        state_q    <= state_d;
        gain_q     <= gain_d;
        fade_frame <= {apply_gain(chain_frame[2*SW-1:SW], gain_d),
                       apply_gain(chain_frame[SW-1:0], gain_d)};
      end
    end
  end

endmodule

// File: rtl/daf.sv
`timescale 1ns/1ps

module daf
  import daf_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  pot_t       pot_vol,
  input  pot_t       pot_amp_com,
  input  pot_t       pot_amp_clp,
  // flanger, clip, compress, fader
  input  logic [3:0] mode_en,
  input  logic       serial_data_in,
  output logic       sck,
  output logic       ws,
  output logic       serial_data_out
);

  logic   bit_strobe;
  logic   frame_strobe;
  frame_t rx_frame;
  logic   rx_valid;
  frame_t chain_frame;
  logic   chain_valid;
  frame_t fade_frame;
  logic   fade_valid;

  clk_div i_clk_div (
    .clk          (clk),
    .rst_n        (rst_n),
    .sck          (sck),
    .ws           (ws),
    .bit_strobe   (bit_strobe),
    .frame_strobe (frame_strobe)
  );

  i2s_rcvr i_i2s_rcvr (
    .clk            (clk),
    .rst_n          (rst_n),
    .bit_strobe     (bit_strobe),
    .frame_strobe   (frame_strobe),
    .serial_data_in (serial_data_in),
    .rx_frame       (rx_frame),
    .rx_valid       (rx_valid)
  );

  effect_chain i_effect_chain (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx_frame    (rx_frame),
    .rx_valid    (rx_valid),
    .pot_vol     (pot_vol),
    .pot_amp_clp (pot_amp_clp),
    .pot_amp_com (pot_amp_com),
    .mode_en     (mode_en),
    .chain_frame (chain_frame),
    .chain_valid (chain_valid)
  );

  fader i_fader (
    .clk         (clk),
    .rst_n       (rst_n),
    .fade_en     (mode_en[0]),
    .chain_frame (chain_frame),
    .chain_valid (chain_valid),
    .fade_frame  (fade_frame),
    .fade_valid  (fade_valid)
  );

  i2s_trnmtr i_i2s_trnmtr (
    .clk             (clk),
    .rst_n           (rst_n),
    .bit_strobe      (bit_strobe),
    .frame_strobe    (frame_strobe),
    .sck             (sck),
    .fade_frame      (fade_frame),
    .fade_valid      (fade_valid),
    .serial_data_out (serial_data_out)
  );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk = ~clk;
    end
  end

  // Release just after a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// File: bench/daf_tb.sv
`timescale 1ns/1ps

module daf_tb
  import daf_pkg::*;
();

  localparam int CLK_NS          = 20;
  localparam int FRAME_CYCLES    = 128;
  localparam int SCK_HALF_CYCLES = 2;
  localparam int N_FRAMES        = 70;
  localparam int CLIP_START      = 6;
  localparam int COMP_START      = 14;
  localparam int FADE_START      = 22;
  localparam int FADE_STOP       = 42;
  localparam int RAND_START      = 45;
  // Two more periods drain the pipeline
  localparam int RUN_FRAMES      = N_FRAMES + 2;

  logic       clk;
  logic       rst_n;
  pot_t       pot_vol;
  pot_t       pot_amp_com;
  pot_t       pot_amp_clp;
  logic [3:0] mode_en;
  logic       serial_data_in;
  logic       sck;
  logic       ws;
  logic       serial_data_out;

  integer seed;
  int     gain_ref;
  int     checks;
  int     errors;
  int     frames_checked;
  frame_t tx_frame;
  frame_t exp_q[$];

  tb_clock #(
    .PERIOD_NS    (CLK_NS),
    .RESET_CYCLES (8)
  ) i_tb_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  daf i_daf (
    .clk             (clk),
    .rst_n           (rst_n),
    .pot_vol         (pot_vol),
    .pot_amp_com     (pot_amp_com),
    .pot_amp_clp     (pot_amp_clp),
    .mode_en         (mode_en),
    .serial_data_in  (serial_data_in),
    .sck             (sck),
    .ws              (ws),
    .serial_data_out (serial_data_out)
  );

  // Volume, clip, compress, then fader gain
  function automatic int process_sample(int s, int vol, int clp, int com,
                                        logic [3:0] mode, int gain);
    int v;
    int lim;
    int th;
    int mag;
    v = (s * vol) >>> 4;
    if (mode[2]) begin
      lim = clp * 2048 + 2047;
      if (v > lim) begin
        v = lim;
      end else if (v < -lim) begin
        v = -lim;
      end
    end
    if (mode[1]) begin
      th  = com * 2048;
      mag = (v < 0) ? -v : v;
      if (mag > th) begin
        mag = th + ((mag - th) >>> 2);
        v   = (v < 0) ? -mag : mag;
      end
    end
    return (v * gain) >>> 4;
  endfunction

  task automatic choose_settings(input int frame_no);
    logic [31:0] r;
    int          left;
    int          right;
    r           = $random(seed);
    pot_vol     = 4'd15;
    pot_amp_clp = r[3:0];
    pot_amp_com = r[7:4];
    mode_en     = 4'b0000;
    if (frame_no >= RAND_START) begin
      pot_vol = r[11:8];
      mode_en = r[15:12];
    end else if (frame_no >= FADE_STOP) begin
      mode_en = 4'b0000;
    end else if (frame_no >= FADE_START) begin
      mode_en = 4'b0001;
    end else if (frame_no >= COMP_START) begin
      mode_en = 4'b0010;
    end else if (frame_no >= CLIP_START) begin
      mode_en = 4'b0100;
    end
    // One gain step per frame
    if (!mode_en[0]) begin
      gain_ref = 16;
    end else if (gain_ref > 0) begin
      gain_ref = gain_ref - 1;
    end
    left  = process_sample(int'(sample_t'(tx_frame[31:16])), int'(pot_vol),
                           int'(pot_amp_clp), int'(pot_amp_com), mode_en, gain_ref);
    right = process_sample(int'(sample_t'(tx_frame[15:0])), int'(pot_vol),
                           int'(pot_amp_clp), int'(pot_amp_com), mode_en, gain_ref);
    exp_q.push_back({16'(left), 16'(right)});
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks = checks + 1;
    assert (actual === expected) else begin
      errors = errors + 1;
      $display("error at %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  // Serial source with a new bit after each falling sck
  initial begin
    int   bit_pos;
    int   frame_no;
    logic sck_prev;
    seed           = 14;
    gain_ref       = 16;
    bit_pos        = 0;
    frame_no       = 0;
    sck_prev       = 1'b0;
    pot_vol        = 4'd15;
    pot_amp_com    = '0;
    pot_amp_clp    = '0;
    mode_en        = '0;
    tx_frame       = $random(seed);
    serial_data_in = tx_frame[31];
    wait (rst_n);
    forever begin
      @(posedge clk);
      #1;
      if (sck_prev && !sck) begin
        bit_pos = bit_pos + 1;
        if (bit_pos == 32) begin
          bit_pos  = 0;
          frame_no = frame_no + 1;
          tx_frame = $random(seed);
        end
        serial_data_in = tx_frame[31 - bit_pos];
        // Settings change mid frame once the previous frame is processed
        if (bit_pos == 16 && frame_no < N_FRAMES) begin
          choose_settings(frame_no);
        end
      end
      sck_prev = sck;
    end
  end

  // Output capture on rising sck
  initial begin
    int          sck_rises;
    int          sck_cycles;
    int          right_bits;
    int          cap_index;
    logic        sck_prev;
    logic        ws_prev;
    logic [15:0] left_word;
    logic [15:0] right_word;
    frame_t      expected;
    checks         = 0;
    errors         = 0;
    frames_checked = 0;
    sck_rises      = 0;
    sck_cycles     = 0;
    right_bits     = 0;
    cap_index      = 0;
    sck_prev       = 1'b0;
    ws_prev        = 1'b0;
    left_word      = '0;
    right_word     = '0;
    wait (rst_n);
    check_value("ws", 0, ws);
    check_value("serial_data_out", 0, serial_data_out);
    forever begin
      @(posedge clk);
      #1;
      sck_cycles = sck_cycles + 1;
      if (sck != sck_prev) begin
        check_value("sck half period", SCK_HALF_CYCLES, sck_cycles);
        sck_cycles = 0;
      end
      if (ws != ws_prev) begin
        check_value("ws level length", 16, sck_rises);
        sck_rises = 0;
        ws_prev   = ws;
      end
      if (sck && !sck_prev) begin
        sck_rises = sck_rises + 1;
        if (!ws) begin
          left_word = {left_word[14:0], serial_data_out};
        end else begin
          right_word = {right_word[14:0], serial_data_out};
          right_bits = right_bits + 1;
        end
      end
      if (right_bits == 16) begin
        right_bits = 0;
        // First two periods carry the cleared pipeline
        expected = '0;
        if (cap_index >= 2) begin
          assert (exp_q.size() > 0) else begin
            errors = errors + 1;
            $display("error at %0d ns: output frame with nothing left to compare", $time);
          end
          if (exp_q.size() > 0) begin
            expected = exp_q.pop_front();
          end
          frames_checked = frames_checked + 1;
        end
        check_value("serial_data_out left", expected[31:16], left_word);
        check_value("serial_data_out right", expected[15:0], right_word);
        cap_index = cap_index + 1;
      end
      sck_prev = sck;
    end
  end

  initial begin
    wait (frames_checked == N_FRAMES);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(RUN_FRAMES * FRAME_CYCLES * CLK_NS * 3 / 2);
    $display("timeout: serial output stopped before all frames were checked");
    $display("checks %0d, errors %0d", checks, errors);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: src.f
+incdir+common
common/daf_pkg.sv
rtl/clk_div.sv
i2s/i2s_rcvr.sv
i2s/i2s_trnmtr.sv
rtl/effect_chain.sv
rtl/fader.sv
rtl/daf.sv
bench/tb_clock.sv
bench/daf_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module daf_tb -Mdir obj_dir -o daf_sim

run: compile
	./obj_dir/daf_sim | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
